//--- hw/crc32_d8.sv
`timescale 1ns/100ps

module crc32_d8 (
	input logic clk,
	input logic reset,
	crc_if.engine crc
);

	// 0x04C11DB7 bit reversed
	localparam logic [31:0] poly = 32'hEDB88320;

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// lsb of the byte goes in first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i]) begin
				r = (r >> 1) ^ poly;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	// clear and a byte in the same cycle start a new sum with that byte
	always_comb begin
		crc_next = crc.clear ? 32'hFFFF_FFFF : crc_q;
		if (crc.en) begin
			crc_next = crc_byte(crc_next, crc.data);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			crc_q <= 32'hFFFF_FFFF;
		end else begin
			crc_q <= crc_next;
		end
	end

	assign crc.crc = ~crc_q;
	assign crc.good = (crc_q == eth_frame_pkg::crc_residue);

endmodule

//--- hw/crc_if.sv
`timescale 1ns/100ps

interface crc_if;
	logic clear;
	logic en;
	logic [7:0] data;
	logic [31:0] crc;
	logic good;

	modport sequencer (
		output clear,
		output en,
		output data,
		input crc,
		input good
	);

	modport engine (
		input clear,
		input en,
		input data,
		output crc,
		output good
	);
endinterface

//--- hw/eth_frame_pkg.sv
package eth_frame_pkg;

	// wire-level delimiters
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hD5;

	// lengths in bytes
	localparam int preamble_len = 7;
	localparam int header_len = 14;
	localparam int min_payload = 46;
	localparam int fcs_len = 4;

	// idle cycles between transmitted frames
	localparam int gap_len = 12;

	// raw register after a good frame including its fcs
	localparam logic [31:0] crc_residue = 32'hDEBB20E3;

	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] ethertype_t;

endpackage

//--- hw/eth_fsm_pkg.sv
package eth_fsm_pkg;

	typedef enum logic [2:0] {
		tx_idle,
		tx_preamble,
		tx_header,
		tx_payload,
		tx_pad,
		tx_fcs,
		tx_gap
	} tx_state_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_preamble,
		rx_header,
		rx_payload,
		rx_drain,
		rx_gap
	} rx_state_t;

endpackage

//--- hw/eth_gmii_mac.sv
`timescale 1ns/100ps

module eth_gmii_mac #(
	parameter int CNT_W = 16
) (
	input logic clk,
	input logic reset,
	input eth_frame_pkg::mac_addr_t tx_dmac,
	input eth_frame_pkg::mac_addr_t tx_smac,
	input eth_frame_pkg::ethertype_t tx_ethertype,
	input logic tx_valid,
	input logic [7:0] tx_data,
	input logic tx_last,
	output logic tx_ready,
	output eth_frame_pkg::mac_addr_t rx_dmac,
	output eth_frame_pkg::mac_addr_t rx_smac,
	output eth_frame_pkg::ethertype_t rx_ethertype,
	output logic rx_header_valid,
	output logic rx_valid,
	output logic [7:0] rx_data,
	output logic rx_last,
	output logic rx_err,
	output logic [7:0] gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er,
	input logic [7:0] gmii_rxd,
	input logic gmii_rx_dv,
	input logic gmii_rx_er,
	output logic [CNT_W-1:0] tx_frames,
	output logic [CNT_W-1:0] rx_frames,
	output logic [CNT_W-1:0] rx_crc_errors,
	output logic [CNT_W-1:0] tx_aborts
);

	logic tx_done;
	logic tx_abort;
	logic rx_done;
	logic rx_bad;

	crc_if tx_crc_if ();
	crc_if rx_crc_if ();

	eth_tx_framer eth_tx_framer_inst (
		.clk(clk),
		.reset(reset),
		.tx_dmac(tx_dmac),
		.tx_smac(tx_smac),
		.tx_ethertype(tx_ethertype),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.tx_ready(tx_ready),
		.gmii_txd(gmii_txd),
		.gmii_tx_en(gmii_tx_en),
		.gmii_tx_er(gmii_tx_er),
		.tx_done(tx_done),
		.tx_abort(tx_abort),
		.crc(tx_crc_if)
	);

	crc32_d8 tx_crc (
		.clk(clk),
		.reset(reset),
		.crc(tx_crc_if)
	);

	eth_rx_deframer eth_rx_deframer_inst (
		.clk(clk),
		.reset(reset),
		.gmii_rxd(gmii_rxd),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.rx_dmac(rx_dmac),
		.rx_smac(rx_smac),
		.rx_ethertype(rx_ethertype),
		.rx_header_valid(rx_header_valid),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.rx_err(rx_err),
		.rx_done(rx_done),
		.rx_bad(rx_bad),
		.crc(rx_crc_if)
	);

	crc32_d8 rx_crc (
		.clk(clk),
		.reset(reset),
		.crc(rx_crc_if)
	);

	eth_stats #(
		.CNT_W(CNT_W)
	) eth_stats_inst (
		.clk(clk),
		.reset(reset),
		.tx_done(tx_done),
		.tx_abort(tx_abort),
		.rx_done(rx_done),
		.rx_bad(rx_bad),
		.tx_frames(tx_frames),
		.rx_frames(rx_frames),
		.rx_crc_errors(rx_crc_errors),
		.tx_aborts(tx_aborts)
	);

endmodule

//--- hw/eth_rx_deframer.sv
`timescale 1ns/100ps

module eth_rx_deframer (
	input logic clk,
	input logic reset,
	input logic [7:0] gmii_rxd,
	input logic gmii_rx_dv,
	input logic gmii_rx_er,
	output eth_frame_pkg::mac_addr_t rx_dmac,
	output eth_frame_pkg::mac_addr_t rx_smac,
	output eth_frame_pkg::ethertype_t rx_ethertype,
	output logic rx_header_valid,
	output logic rx_valid,
	output logic [7:0] rx_data,
	output logic rx_last,
	output logic rx_err,
	output logic rx_done,
	output logic rx_bad,
	crc_if.sequencer crc
);

	localparam int hdr_w = eth_frame_pkg::header_len * 8;
	localparam int hold_len = eth_frame_pkg::fcs_len;

	eth_fsm_pkg::rx_state_t state;
	eth_fsm_pkg::rx_state_t state_next;
	logic [7:0] rxd_q;
	logic dv_q;
	logic dv_d;
	logic er_q;
	logic [3:0] cnt;
	logic [hdr_w-1:0] hdr;
	logic [7:0] hold [hold_len];
	logic [2:0] fill;
	logic err_seen;
	logic hdr_shift;
	logic pay_shift;

	assign hdr_shift = (state == eth_fsm_pkg::rx_header) && dv_q;
	assign pay_shift = (state == eth_fsm_pkg::rx_payload) && dv_q;

	// every byte after the sfd is summed, fcs included
	assign crc.clear = (state == eth_fsm_pkg::rx_idle);
	assign crc.en = hdr_shift || pay_shift;
	assign crc.data = rxd_q;

	assign {rx_dmac, rx_smac, rx_ethertype} = hdr;

	// the byte on the output is last once the carrier has dropped
	assign rx_last = rx_valid && (state == eth_fsm_pkg::rx_payload) && !dv_q;
	assign rx_err = rx_last && (err_seen || !crc.good);
	assign rx_done = rx_last;
	assign rx_bad = rx_err;

	always_comb begin
		state_next = state;
		case (state)
			eth_fsm_pkg::rx_idle: begin
				if (dv_q && !dv_d) begin
					state_next = eth_fsm_pkg::rx_preamble;
				end
			end
			eth_fsm_pkg::rx_preamble: begin
				if (!dv_q) begin
					state_next = eth_fsm_pkg::rx_gap;
				end else if (rxd_q == eth_frame_pkg::sfd_byte) begin
					state_next = eth_fsm_pkg::rx_header;
				end else if (rxd_q != eth_frame_pkg::preamble_byte) begin
					state_next = eth_fsm_pkg::rx_drain;
				end
			end
			eth_fsm_pkg::rx_header: begin
				if (!dv_q) begin
					state_next = eth_fsm_pkg::rx_gap;
				end else if (cnt == 4'(eth_frame_pkg::header_len - 1)) begin
					state_next = eth_fsm_pkg::rx_payload;
				end
			end
			eth_fsm_pkg::rx_payload, eth_fsm_pkg::rx_drain: begin
				if (!dv_q) begin
					state_next = eth_fsm_pkg::rx_gap;
				end
			end
			eth_fsm_pkg::rx_gap: begin
				// carrier back without a gap is thrown away
				state_next = dv_q ? eth_fsm_pkg::rx_drain : eth_fsm_pkg::rx_idle;
			end
			default: begin
				state_next = eth_fsm_pkg::rx_idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= eth_fsm_pkg::rx_idle;
			dv_q <= 1'b0;
			dv_d <= 1'b0;
			er_q <= 1'b0;
			cnt <= '0;
			fill <= '0;
			err_seen <= 1'b0;
			rx_valid <= 1'b0;
			rx_header_valid <= 1'b0;
		end else begin
			dv_q <= gmii_rx_dv;
			dv_d <= dv_q;
			er_q <= gmii_rx_er;
			state <= state_next;
			rx_header_valid <= hdr_shift && (cnt == 4'(eth_frame_pkg::header_len - 1));
			rx_valid <= pay_shift && (fill == 3'(hold_len));
			cnt <= hdr_shift ? cnt + 4'd1 : 4'd0;
			if (state == eth_fsm_pkg::rx_idle) begin
				fill <= '0;
			end else if (pay_shift && fill != 3'(hold_len)) begin
				fill <= fill + 3'd1;
			end
			// sticky over the whole frame
			if (state == eth_fsm_pkg::rx_idle) begin
				err_seen <= dv_q && er_q;
			end else if (dv_q && er_q) begin
				err_seen <= 1'b1;
			end
		end
	end

	// four bytes held back so the fcs never reaches rx_data
	always_ff @(posedge clk) begin
		rxd_q <= gmii_rxd;
		if (hdr_shift) begin
			hdr <= {hdr[hdr_w-9:0], rxd_q};
		end
		if (pay_shift) begin
			hold[0] <= rxd_q;
			for (int i = 1; i < hold_len; i++) begin
				hold[i] <= hold[i-1];
			end
			rx_data <= hold[hold_len-1];
		end
	end

endmodule

//--- hw/eth_stats.sv
`timescale 1ns/100ps

module eth_stats #(
	parameter int CNT_W = 16
) (
	input logic clk,
	input logic reset,
	input logic tx_done,
	input logic tx_abort,
	input logic rx_done,
	input logic rx_bad,
	output logic [CNT_W-1:0] tx_frames,
	output logic [CNT_W-1:0] rx_frames,
	output logic [CNT_W-1:0] rx_crc_errors,
	output logic [CNT_W-1:0] tx_aborts
);

	logic [3:0] evt;
	logic [CNT_W-1:0] count [4];

	// slot order matches the output assigns below
	assign evt = {rx_bad, rx_done, tx_abort, tx_done};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				// stick at all ones
				if (evt[i] && count[i] != '1) begin
					count[i] <= count[i] + 1'b1;
				end
			end
		end
	end

	assign tx_frames = count[0];
	assign tx_aborts = count[1];
	assign rx_frames = count[2];
	assign rx_crc_errors = count[3];

endmodule

//--- hw/eth_tx_framer.sv
`timescale 1ns/100ps

module eth_tx_framer (
	input logic clk,
	input logic reset,
	input eth_frame_pkg::mac_addr_t tx_dmac,
	input eth_frame_pkg::mac_addr_t tx_smac,
	input eth_frame_pkg::ethertype_t tx_ethertype,
	input logic tx_valid,
	input logic [7:0] tx_data,
	input logic tx_last,
	output logic tx_ready,
	output logic [7:0] gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er,
	output logic tx_done,
	output logic tx_abort,
	crc_if.sequencer crc
);

	localparam int hdr_w = eth_frame_pkg::header_len * 8;

	eth_fsm_pkg::tx_state_t state;
	eth_fsm_pkg::tx_state_t state_next;
	logic [15:0] cnt;
	logic [15:0] cnt_next;
	logic [hdr_w-1:0] hdr;
	logic [7:0] txd_next;
	logic tx_en_next;
	logic tx_er_next;
	logic done_next;
	logic abort_next;
	logic crc_en;

	assign tx_ready = (state == eth_fsm_pkg::tx_payload);
	assign crc.clear = (state == eth_fsm_pkg::tx_idle);
	assign crc.en = crc_en;
	assign crc.data = txd_next;

	// state picks the byte that goes on the wire next cycle
	always_comb begin
		state_next = state;
		cnt_next = cnt + 16'd1;
		txd_next = 8'h00;
		tx_en_next = 1'b1;
		tx_er_next = 1'b0;
		done_next = 1'b0;
		abort_next = 1'b0;
		crc_en = 1'b0;
		case (state)
			eth_fsm_pkg::tx_idle: begin
				cnt_next = '0;
				tx_en_next = tx_valid;
				if (tx_valid) begin
					txd_next = eth_frame_pkg::preamble_byte;
					state_next = eth_fsm_pkg::tx_preamble;
				end
			end
			eth_fsm_pkg::tx_preamble: begin
				if (cnt == 16'(eth_frame_pkg::preamble_len - 1)) begin
					txd_next = eth_frame_pkg::sfd_byte;
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_header;
				end else begin
					txd_next = eth_frame_pkg::preamble_byte;
				end
			end
			eth_fsm_pkg::tx_header: begin
				txd_next = hdr[hdr_w-1 -: 8];
				crc_en = 1'b1;
				if (cnt == 16'(eth_frame_pkg::header_len - 1)) begin
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_payload;
				end
			end
			eth_fsm_pkg::tx_payload: begin
				if (tx_valid) begin
					txd_next = tx_data;
					crc_en = 1'b1;
					if (tx_last) begin
						if (cnt < 16'(eth_frame_pkg::min_payload - 1)) begin
							state_next = eth_fsm_pkg::tx_pad;
						end else begin
							cnt_next = '0;
							state_next = eth_fsm_pkg::tx_fcs;
						end
					end
				end else begin
					// underrun aborts the frame without an fcs
					tx_er_next = 1'b1;
					abort_next = 1'b1;
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_gap;
				end
			end
			eth_fsm_pkg::tx_pad: begin
				crc_en = 1'b1;
				if (cnt == 16'(eth_frame_pkg::min_payload - 1)) begin
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_fcs;
				end
			end
			eth_fsm_pkg::tx_fcs: begin
				// low byte first
				txd_next = crc.crc[{cnt[1:0], 3'b000} +: 8];
				if (cnt == 16'(eth_frame_pkg::fcs_len - 1)) begin
					done_next = 1'b1;
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_gap;
				end
			end
			eth_fsm_pkg::tx_gap: begin
				tx_en_next = 1'b0;
				if (cnt == 16'(eth_frame_pkg::gap_len - 1)) begin
					cnt_next = '0;
					state_next = eth_fsm_pkg::tx_idle;
				end
			end
			default: begin
				tx_en_next = 1'b0;
				cnt_next = '0;
				state_next = eth_fsm_pkg::tx_idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= eth_fsm_pkg::tx_idle;
			cnt <= '0;
			gmii_txd <= 8'h00;
			gmii_tx_en <= 1'b0;
			gmii_tx_er <= 1'b0;
			tx_done <= 1'b0;
			tx_abort <= 1'b0;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
			gmii_txd <= txd_next;
			gmii_tx_en <= tx_en_next;
			gmii_tx_er <= tx_er_next;
			tx_done <= done_next;
			tx_abort <= abort_next;
		end
	end

	// header captured as the frame starts, sent msb byte first
	always_ff @(posedge clk) begin
		if (state == eth_fsm_pkg::tx_idle && tx_valid) begin
			hdr <= {tx_dmac, tx_smac, tx_ethertype};
		end else if (state == eth_fsm_pkg::tx_header) begin
			hdr <= {hdr[hdr_w-9:0], 8'h00};
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_eth_gmii_mac -f verilog.f -o tb_eth_gmii_mac
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_eth_gmii_mac > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- sim/eth_gmii_mac_properties.sv
`timescale 1ns/100ps

module eth_gmii_mac_properties (
	input logic clk,
	input logic reset,
	input logic tx_valid,
	input logic tx_ready,
	input logic [7:0] gmii_txd,
	input logic gmii_tx_en,
	input logic gmii_tx_er
);

	// byte position on the wire since gmii_tx_en rose
	logic [3:0] pos;
	// earlier cycles with gmii_tx_en low
	logic [4:0] low_run;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pos <= '0;
		end else if (!gmii_tx_en) begin
			pos <= '0;
		end else if (pos != 4'hF) begin
			pos <= pos + 4'd1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			low_run <= '0;
		end else if (gmii_tx_en) begin
			low_run <= '0;
		end else if (low_run != '1) begin
			low_run <= low_run + 5'd1;
		end
	end

	// leaves tx_idle one cycle after tx_valid
	start_after_valid: assert property (@(posedge clk) disable iff (reset)
		$rose(gmii_tx_en) |-> $past(tx_valid))
		else $error("gmii_tx_en rose without tx_valid seen in tx_idle");

	// tx_gap has run out once low_run reaches gap_len - 1
	start_from_idle: assert property (@(posedge clk) disable iff (reset)
		!gmii_tx_en && low_run >= 5'(eth_frame_pkg::gap_len - 1) && tx_valid
		|=> gmii_tx_en)
		else $error("tx_valid in tx_idle did not start the frame one cycle later");

	preamble_bytes: assert property (@(posedge clk) disable iff (reset)
		gmii_tx_en && pos < 4'd7 |-> gmii_txd == eth_frame_pkg::preamble_byte)
		else $error("wrong byte during tx_preamble");

	sfd_after_preamble: assert property (@(posedge clk) disable iff (reset)
		gmii_tx_en && pos == 4'd7 |-> gmii_txd == eth_frame_pkg::sfd_byte)
		else $error("sfd missing at the end of tx_preamble");

	// underrun in tx_payload gives one error byte, then tx_gap
	underrun_error_byte: assert property (@(posedge clk) disable iff (reset)
		tx_ready && !tx_valid |=> gmii_tx_er && gmii_tx_en)
		else $error("underrun in tx_payload without an error byte");

	error_only_on_underrun: assert property (@(posedge clk) disable iff (reset)
		gmii_tx_er |-> $past(tx_ready && !tx_valid))
		else $error("gmii_tx_er high without an underrun");

	abort_ends_frame: assert property (@(posedge clk) disable iff (reset)
		gmii_tx_er |=> !gmii_tx_en)
		else $error("frame went on after the error byte instead of tx_gap");

endmodule

bind eth_gmii_mac eth_gmii_mac_properties eth_gmii_mac_properties_inst (
	.clk(clk),
	.reset(reset),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready),
	.gmii_txd(gmii_txd),
	.gmii_tx_en(gmii_tx_en),
	.gmii_tx_er(gmii_tx_er)
);

//--- sim/tb_eth_gmii_mac.sv
`timescale 1ns/100ps

module tb_eth_gmii_mac;

	localparam int CNT_W = 16;
	localparam int max_wait = 2000;
	// wire index of the first payload byte, counted from the first preamble byte
	localparam int payload_at = eth_frame_pkg::preamble_len + 1 + eth_frame_pkg::header_len;

	logic clk;
	logic reset;
	eth_frame_pkg::mac_addr_t tx_dmac, tx_smac, rx_dmac, rx_smac;
	eth_frame_pkg::ethertype_t tx_ethertype, rx_ethertype;
	logic tx_valid, tx_last, tx_ready;
	logic [7:0] tx_data, rx_data, gmii_txd, gmii_rxd;
	logic rx_header_valid, rx_valid, rx_last, rx_err;
	logic gmii_tx_en, gmii_tx_er, gmii_rx_dv, gmii_rx_er;
	logic [CNT_W-1:0] tx_frames, rx_frames, rx_crc_errors, tx_aborts;

	logic [15:0] wire_idx;
	int flip_idx;
	logic [31:0] lfsr_state;
	logic [7:0] exp_q [$];
	logic [7:0] got_q [$];
	eth_frame_pkg::mac_addr_t exp_dmac, exp_smac, got_dmac, got_smac;
	eth_frame_pkg::ethertype_t exp_type, got_type;
	logic hdr_seen, last_seen, last_err;
	string cur_test;
	int errors, tests_passed, tests_failed, idle_cnt, gaps_seen;
	int exp_tx_frames, exp_rx_frames, exp_crc_errors, exp_aborts;

	always #50 clk = ~clk;

	eth_gmii_mac #(
		.CNT_W(CNT_W)
	) eth_gmii_mac_inst (
		.clk(clk), .reset(reset),
		.tx_dmac(tx_dmac), .tx_smac(tx_smac), .tx_ethertype(tx_ethertype),
		.tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last), .tx_ready(tx_ready),
		.rx_dmac(rx_dmac), .rx_smac(rx_smac), .rx_ethertype(rx_ethertype),
		.rx_header_valid(rx_header_valid), .rx_valid(rx_valid), .rx_data(rx_data),
		.rx_last(rx_last), .rx_err(rx_err),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.tx_frames(tx_frames), .rx_frames(rx_frames),
		.rx_crc_errors(rx_crc_errors), .tx_aborts(tx_aborts)
	);

	// loopback, bit 0 of the chosen wire byte flipped
	assign gmii_rxd = gmii_txd ^ {7'd0, int'(wire_idx) == flip_idx};
	assign gmii_rx_dv = gmii_tx_en;
	assign gmii_rx_er = gmii_tx_er;

	always @(posedge clk) begin
		wire_idx <= (gmii_tx_en && !reset) ? wire_idx + 16'd1 : 16'd0;
	end

	// gap monitor and receive capture
	always @(negedge clk) begin
		if (reset) begin
			idle_cnt = 100;
			gaps_seen = 0;
		end else begin
			if (gmii_tx_en) begin
				if (idle_cnt > 0) begin
					assert (idle_cnt >= eth_frame_pkg::gap_len) else begin
						$display("CHECK FAILED %s gap: expected at least %0d, actual %0d",
							cur_test, eth_frame_pkg::gap_len, idle_cnt);
						errors++;
					end
					gaps_seen++;
				end
				idle_cnt = 0;
			end else begin
				idle_cnt++;
			end
			if (rx_header_valid) begin
				got_dmac = rx_dmac;
				got_smac = rx_smac;
				got_type = rx_ethertype;
				hdr_seen = 1'b1;
			end
			if (rx_valid) begin
				got_q.push_back(rx_data);
			end
			if (rx_last) begin
				last_err = rx_err;
				last_seen = 1'b1;
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (exp == act) else begin
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input int err0);
		if (errors == err0) begin
			tests_passed++;
			$display("test %s: pass", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", cur_test, errors - err0);
		end
	endtask

	// drop_at and flip_at are payload indices, -1 for none
	task automatic send_frame(input int len, input int drop_at, input int flip_at);
		logic [31:0] r;
		logic [7:0] data [$];
		int waited;
		random_bits(16, r);
		exp_dmac[47:32] = r[15:0];
		random_bits(32, r);
		exp_dmac[31:0] = r;
		random_bits(16, r);
		exp_smac[47:32] = r[15:0];
		random_bits(32, r);
		exp_smac[31:0] = r;
		random_bits(16, r);
		exp_type = r[15:0];
		exp_q.delete();
		got_q.delete();
		for (int i = 0; i < len; i++) begin
			random_bits(8, r);
			data.push_back(r[7:0]);
			exp_q.push_back(r[7:0] ^ {7'd0, i == flip_at});
		end
		while (exp_q.size() < eth_frame_pkg::min_payload) begin
			exp_q.push_back(8'h00);
		end
		flip_idx = (flip_at < 0) ? -1 : payload_at + flip_at;
		hdr_seen = 1'b0;
		last_seen = 1'b0;
		@(negedge clk);
		tx_dmac = exp_dmac;
		tx_smac = exp_smac;
		tx_ethertype = exp_type;
		tx_valid = 1'b1;
		tx_data = data[0];
		tx_last = (len == 1);
		waited = 0;
		while (!tx_ready && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (!tx_ready) begin
			$display("%s: timeout waiting for tx_ready", cur_test);
			errors++;
			tx_valid = 1'b0;
			return;
		end
		for (int i = 1; i < len; i++) begin
			@(negedge clk);
			if (i == drop_at) begin
				tx_valid = 1'b0;
				break;
			end
			tx_data = data[i];
			tx_last = (i == len - 1);
		end
		@(negedge clk);
		tx_valid = 1'b0;
		tx_last = 1'b0;
	endtask

	task automatic wait_rx(output logic ok);
		int waited;
		waited = 0;
		while (!last_seen && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		ok = last_seen;
		flip_idx = -1;
		if (!ok) begin
			$display("%s: timeout waiting for rx_last", cur_test);
			errors++;
		end
	endtask

	task automatic frame_test(input string name, input int len, input int flip_at,
			input logic exp_err);
		int err0;
		logic ok;
		cur_test = name;
		err0 = errors;
		send_frame(len, -1, flip_at);
		wait_rx(ok);
		if (ok) begin
			check_value("header pulse", 64'd1, 64'(hdr_seen));
			check_value("rx_dmac", 64'(exp_dmac), 64'(got_dmac));
			check_value("rx_smac", 64'(exp_smac), 64'(got_smac));
			check_value("rx_ethertype", 64'(exp_type), 64'(got_type));
			check_value("payload length", 64'(exp_q.size()), 64'(got_q.size()));
			for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
				check_value("payload byte", 64'(exp_q[i]), 64'(got_q[i]));
			end
			check_value("rx_err", 64'(exp_err), 64'(last_err));
		end
		exp_tx_frames++;
		exp_rx_frames++;
		if (exp_err) begin
			exp_crc_errors++;
		end
		// counters move one cycle after the pulse
		repeat (2) @(negedge clk);
		check_value("rx_crc_errors", 64'(exp_crc_errors), 64'(rx_crc_errors));
		finish_test(err0);
	endtask

	initial begin
		int err0;
		logic ok;
		logic [31:0] r;
		logic [31:0] k;
		clk = 1'b0;
		reset = 1'b1;
		tx_dmac = '0;
		tx_smac = '0;
		tx_ethertype = '0;
		tx_valid = 1'b0;
		tx_data = 8'h00;
		tx_last = 1'b0;
		flip_idx = -1;
		lfsr_state = 32'd72837;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		exp_tx_frames = 0;
		exp_rx_frames = 0;
		exp_crc_errors = 0;
		exp_aborts = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		cur_test = "reset";
		err0 = errors;
		check_value("gmii_tx_en", 64'd0, 64'(gmii_tx_en));
		check_value("gmii_tx_er", 64'd0, 64'(gmii_tx_er));
		check_value("tx_ready", 64'd0, 64'(tx_ready));
		check_value("rx_valid", 64'd0, 64'(rx_valid));
		check_value("rx_header_valid", 64'd0, 64'(rx_header_valid));
		check_value("tx_frames", 64'd0, 64'(tx_frames));
		check_value("rx_frames", 64'd0, 64'(rx_frames));
		check_value("rx_crc_errors", 64'd0, 64'(rx_crc_errors));
		check_value("tx_aborts", 64'd0, 64'(tx_aborts));
		finish_test(err0);

		for (int n = 0; n < 3; n++) begin
			random_bits(7, r);
			frame_test("loopback", 46 + int'(r % 75), -1, 1'b0);
		end
		for (int n = 0; n < 2; n++) begin
			random_bits(6, r);
			frame_test("padding", 1 + int'(r % 45), -1, 1'b0);
		end
		random_bits(7, r);
		random_bits(5, k);
		frame_test("corrupt", 46 + int'(r % 75), int'(k), 1'b1);

		cur_test = "underrun";
		err0 = errors;
		send_frame(60, 20, -1);
		wait_rx(ok);
		if (ok) begin
			check_value("rx_err", 64'd1, 64'(last_err));
		end
		exp_aborts++;
		exp_rx_frames++;
		exp_crc_errors++;
		repeat (2) @(negedge clk);
		check_value("tx_aborts", 64'(exp_aborts), 64'(tx_aborts));
		finish_test(err0);

		cur_test = "gap_and_counters";
		err0 = errors;
		check_value("gaps seen", 64'(exp_tx_frames + exp_aborts), 64'(gaps_seen));
		check_value("tx_frames", 64'(exp_tx_frames), 64'(tx_frames));
		check_value("rx_frames", 64'(exp_rx_frames), 64'(rx_frames));
		check_value("rx_crc_errors", 64'(exp_crc_errors), 64'(rx_crc_errors));
		check_value("tx_aborts", 64'(exp_aborts), 64'(tx_aborts));
		finish_test(err0);

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
hw/eth_frame_pkg.sv
hw/eth_fsm_pkg.sv
hw/crc_if.sv
hw/crc32_d8.sv
hw/eth_tx_framer.sv
hw/eth_rx_deframer.sv
hw/eth_stats.sv
hw/eth_gmii_mac.sv
sim/eth_gmii_mac_properties.sv
sim/tb_eth_gmii_mac.sv
